// ==== Makefile ====
TOP := tb_ooo_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f tb.f -o V$(TOP)

# pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^test passed$$"

clean:
	rm -rf obj_dir

// ==== hdl/cdb_arbiter.sv ====
`timescale 1ns/1ns

module cdb_arbiter (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           alu_res_valid,
    input  ooo_pkg::tag_t  alu_res_tag,
    input  ooo_pkg::data_t alu_res_data,
    input  logic           mul_res_valid,
    input  ooo_pkg::tag_t  mul_res_tag,
    input  ooo_pkg::data_t mul_res_data,
    output logic           alu_grant,
    output logic           cdb_valid,
    output ooo_pkg::tag_t  cdb_tag,
    output ooo_pkg::data_t cdb_data
);

    // mul pipeline cannot wait, so it always wins
    assign alu_grant = alu_res_valid && !mul_res_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= mul_res_valid || alu_res_valid;
        end
    end

    // winner onto the bus, one result per cycle
    always_ff @(posedge clk) begin
        if (mul_res_valid) begin
            cdb_tag  <= mul_res_tag;
            cdb_data <= mul_res_data;
        end else begin
            cdb_tag  <= alu_res_tag;
            cdb_data <= alu_res_data;
        end
    end

endmodule

// ==== hdl/dispatch_rename.sv ====
`timescale 1ns/1ns
`include "ooo_config.svh"

module dispatch_rename (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              disp_valid,
    input  ooo_pkg::op_t      disp_op,
    input  ooo_pkg::reg_idx_t disp_rd,
    input  ooo_pkg::reg_idx_t disp_rs1,
    input  ooo_pkg::reg_idx_t disp_rs2,
    input  ooo_pkg::data_t    disp_imm,
    input  logic              alu_has_free,
    input  ooo_pkg::tag_t     alu_free_tag,
    input  logic              mul_has_free,
    input  ooo_pkg::tag_t     mul_free_tag,
    input  logic              cdb_valid,
    input  ooo_pkg::tag_t     cdb_tag,
    input  ooo_pkg::data_t    cdb_data,
    input  ooo_pkg::reg_idx_t arch_addr,
    output logic              disp_ready,
    output logic              alu_alloc,
    output logic              mul_alloc,
    output ooo_pkg::op_t      rs_op,
    output logic              src1_ready,
    output ooo_pkg::tag_t     src1_tag,
    output ooo_pkg::data_t    src1_val,
    output logic              src2_ready,
    output ooo_pkg::tag_t     src2_tag,
    output ooo_pkg::data_t    src2_val,
    output ooo_pkg::data_t    arch_data,
    output logic              idle
);
    import ooo_pkg::*;

    // enough room for every station entry in flight
    localparam int CNT_W = $clog2(2 * `OOO_RS_DEPTH) + 1;

    data_t                   regs    [`OOO_NUM_REGS];
    tag_t                    reg_tag [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0] busy;
    logic [CNT_W-1:0]        inflight;
    logic                    is_mul;
    logic                    accept;
    tag_t                    dest_tag;

    // mul goes to its own station, the rest to the alu
    assign is_mul     = (disp_op == OP_MUL);
    assign disp_ready = is_mul ? mul_has_free : alu_has_free;
    assign accept     = disp_valid && disp_ready;
    assign alu_alloc  = accept && !is_mul;
    assign mul_alloc  = accept && is_mul;
    assign dest_tag   = is_mul ? mul_free_tag : alu_free_tag;
    assign rs_op      = disp_op;

    // operand read with bypass from this cycle's broadcast
    always_comb begin
        src1_ready = !busy[disp_rs1] || (cdb_valid && reg_tag[disp_rs1] == cdb_tag);
        src1_tag   = reg_tag[disp_rs1];
        src1_val   = busy[disp_rs1] ? cdb_data : regs[disp_rs1];
        src2_ready = !busy[disp_rs2] || (cdb_valid && reg_tag[disp_rs2] == cdb_tag);
        src2_tag   = reg_tag[disp_rs2];
        src2_val   = busy[disp_rs2] ? cdb_data : regs[disp_rs2];
        // li carries the immediate as a ready first source
        if (disp_op == OP_LI) begin
            src1_ready = 1'b1;
            src1_val   = disp_imm;
            src2_ready = 1'b1;
        end
    end

    // write-back on tag match, a same-edge rename wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= '0;
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                if (cdb_valid && busy[i] && reg_tag[i] == cdb_tag) begin
                    regs[i] <= cdb_data;
                    busy[i] <= 1'b0;
                end
                if (accept && disp_rd == reg_idx_t'(i)) begin
                    busy[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            reg_tag[disp_rd] <= dest_tag;
        end
    end

    // one broadcast per accepted instruction, so this counts what is still out
    // also catches results whose register was renamed again (waw)
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inflight <= '0;
        end else begin
            inflight <= inflight + CNT_W'(accept) - CNT_W'(cdb_valid);
        end
    end

    assign idle      = !(|busy) && (inflight == '0);
    assign arch_data = regs[arch_addr];

endmodule

// ==== hdl/exec_units.sv ====
`timescale 1ns/1ns
`include "ooo_config.svh"

module exec_units (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           alu_issue_valid,
    input  ooo_pkg::op_t   alu_op,
    input  ooo_pkg::data_t alu_a,
    input  ooo_pkg::data_t alu_b,
    input  ooo_pkg::tag_t  alu_tag,
    input  logic           mul_issue_valid,
    input  ooo_pkg::data_t mul_a,
    input  ooo_pkg::data_t mul_b,
    input  ooo_pkg::tag_t  mul_tag,
    input  logic           alu_grant,
    output logic           alu_ready,
    output logic           alu_res_valid,
    output ooo_pkg::tag_t  alu_res_tag,
    output ooo_pkg::data_t alu_res_data,
    output logic           mul_res_valid,
    output ooo_pkg::tag_t  mul_res_tag,
    output ooo_pkg::data_t mul_res_data
);
    import ooo_pkg::*;

    data_t alu_out;
    logic  alu_load;
    logic  mv [`OOO_MUL_STAGES];
    tag_t  mt [`OOO_MUL_STAGES];
    data_t md [`OOO_MUL_STAGES];

    always_comb begin
        case (alu_op)
            OP_LI:   alu_out = alu_a;
            OP_ADD:  alu_out = alu_a + alu_b;
            OP_SUB:  alu_out = alu_a - alu_b;
            OP_AND:  alu_out = alu_a & alu_b;
            OP_OR:   alu_out = alu_a | alu_b;
            OP_XOR:  alu_out = alu_a ^ alu_b;
            default: alu_out = '0;
        endcase
    end

    // result register holds until the arbiter takes it
    assign alu_ready = !alu_res_valid || alu_grant;
    assign alu_load  = alu_issue_valid && alu_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_res_valid <= 1'b0;
        end else if (alu_load) begin
            alu_res_valid <= 1'b1;
        end else if (alu_grant) begin
            alu_res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (alu_load) begin
            alu_res_tag  <= alu_tag;
            alu_res_data <= alu_out;
        end
    end

    // multiplier, never stalls, low word of the product only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `OOO_MUL_STAGES; s++) begin
                mv[s] <= 1'b0;
            end
        end else begin
            mv[0] <= mul_issue_valid;
            for (int s = 1; s < `OOO_MUL_STAGES; s++) begin
                mv[s] <= mv[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        mt[0] <= mul_tag;
        md[0] <= mul_a * mul_b;
        for (int s = 1; s < `OOO_MUL_STAGES; s++) begin
            mt[s] <= mt[s-1];
            md[s] <= md[s-1];
        end
    end

    assign mul_res_valid = mv[`OOO_MUL_STAGES-1];
    assign mul_res_tag   = mt[`OOO_MUL_STAGES-1];
    assign mul_res_data  = md[`OOO_MUL_STAGES-1];

endmodule

// ==== hdl/ooo_core.sv ====
`timescale 1ns/1ns

module ooo_core (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              disp_valid,
    input  ooo_pkg::op_t      disp_op,
    input  ooo_pkg::reg_idx_t disp_rd,
    input  ooo_pkg::reg_idx_t disp_rs1,
    input  ooo_pkg::reg_idx_t disp_rs2,
    input  ooo_pkg::data_t    disp_imm,
    output logic              disp_ready,
    output logic              cdb_valid,
    output ooo_pkg::tag_t     cdb_tag,
    output ooo_pkg::data_t    cdb_data,
    input  ooo_pkg::reg_idx_t arch_addr,
    output ooo_pkg::data_t    arch_data,
    output logic              idle
);
    import ooo_pkg::*;

    // dispatch side
    logic  alu_has_free, mul_has_free, alu_alloc, mul_alloc;
    tag_t  alu_free_tag, mul_free_tag;
    op_t   rs_op;
    logic  src1_ready, src2_ready;
    tag_t  src1_tag, src2_tag;
    data_t src1_val, src2_val;

    // issue side
    logic  alu_issue_valid, mul_issue_valid, alu_ready;
    op_t   alu_issue_op;
    data_t alu_issue_a, alu_issue_b, mul_issue_a, mul_issue_b;
    tag_t  alu_issue_tag, mul_issue_tag;

    // results into the arbiter
    logic  alu_res_valid, mul_res_valid, alu_grant;
    tag_t  alu_res_tag, mul_res_tag;
    data_t alu_res_data, mul_res_data;

    // mul station issues every cycle it has work
    logic  mul_exec_ready;
    assign mul_exec_ready = 1'b1;

    dispatch_rename u_dispatch (
        .clk, .rst_n, .disp_valid, .disp_op, .disp_rd, .disp_rs1, .disp_rs2, .disp_imm,
        .alu_has_free, .alu_free_tag, .mul_has_free, .mul_free_tag,
        .cdb_valid, .cdb_tag, .cdb_data, .arch_addr,
        .disp_ready, .alu_alloc, .mul_alloc, .rs_op,
        .src1_ready, .src1_tag, .src1_val, .src2_ready, .src2_tag, .src2_val,
        .arch_data, .idle
    );

    reservation_station #(.UNIT(1'b0)) u_rs_alu (
        .clk, .rst_n, .alloc(alu_alloc), .op(rs_op),
        .src1_ready, .src1_tag, .src1_val, .src2_ready, .src2_tag, .src2_val,
        .exec_ready(alu_ready), .cdb_valid, .cdb_tag, .cdb_data,
        .has_free(alu_has_free), .free_tag(alu_free_tag),
        .issue_valid(alu_issue_valid), .issue_op(alu_issue_op),
        .issue_a(alu_issue_a), .issue_b(alu_issue_b), .issue_tag(alu_issue_tag)
    );

    // only one mul opcode, so the stored op is not needed downstream
    reservation_station #(.UNIT(1'b1)) u_rs_mul (
        .clk, .rst_n, .alloc(mul_alloc), .op(rs_op),
        .src1_ready, .src1_tag, .src1_val, .src2_ready, .src2_tag, .src2_val,
        .exec_ready(mul_exec_ready), .cdb_valid, .cdb_tag, .cdb_data,
        .has_free(mul_has_free), .free_tag(mul_free_tag),
        .issue_valid(mul_issue_valid), .issue_op(),
        .issue_a(mul_issue_a), .issue_b(mul_issue_b), .issue_tag(mul_issue_tag)
    );

    exec_units u_exec (
        .clk, .rst_n, .alu_issue_valid, .alu_op(alu_issue_op),
        .alu_a(alu_issue_a), .alu_b(alu_issue_b), .alu_tag(alu_issue_tag),
        .mul_issue_valid, .mul_a(mul_issue_a), .mul_b(mul_issue_b), .mul_tag(mul_issue_tag),
        .alu_grant, .alu_ready, .alu_res_valid, .alu_res_tag, .alu_res_data,
        .mul_res_valid, .mul_res_tag, .mul_res_data
    );

    cdb_arbiter u_arb (
        .clk, .rst_n, .alu_res_valid, .alu_res_tag, .alu_res_data,
        .mul_res_valid, .mul_res_tag, .mul_res_data,
        .alu_grant, .cdb_valid, .cdb_tag, .cdb_data
    );

endmodule

// ==== hdl/ooo_pkg.sv ====
`include "ooo_config.svh"

package ooo_pkg;

    // operand and result value
    typedef logic [`OOO_XLEN-1:0] data_t;

    // architectural register number
    typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_idx_t;

    // producer tag, top bit selects the unit (0 alu, 1 mul)
    // low bits are the station entry index
    typedef logic [$clog2(`OOO_RS_DEPTH):0] tag_t;

    typedef enum logic [2:0] {
        OP_LI  = 3'd0,
        OP_ADD = 3'd1,
        OP_SUB = 3'd2,
        OP_AND = 3'd3,
        OP_OR  = 3'd4,
        OP_XOR = 3'd5,
        OP_MUL = 3'd6
    } op_t;

    // issued covers both execution and waiting for the bus
    typedef enum logic [1:0] {
        ENT_FREE   = 2'd0,
        ENT_WAIT   = 2'd1,
        ENT_ISSUED = 2'd2
    } ent_state_t;

endpackage

// ==== hdl/reservation_station.sv ====
`timescale 1ns/1ns
`include "ooo_config.svh"

module reservation_station #(
    parameter logic UNIT = 1'b0
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           alloc,
    input  ooo_pkg::op_t   op,
    input  logic           src1_ready,
    input  ooo_pkg::tag_t  src1_tag,
    input  ooo_pkg::data_t src1_val,
    input  logic           src2_ready,
    input  ooo_pkg::tag_t  src2_tag,
    input  ooo_pkg::data_t src2_val,
    input  logic           exec_ready,
    input  logic           cdb_valid,
    input  ooo_pkg::tag_t  cdb_tag,
    input  ooo_pkg::data_t cdb_data,
    output logic           has_free,
    output ooo_pkg::tag_t  free_tag,
    output logic           issue_valid,
    output ooo_pkg::op_t   issue_op,
    output ooo_pkg::data_t issue_a,
    output ooo_pkg::data_t issue_b,
    output ooo_pkg::tag_t  issue_tag
);
    import ooo_pkg::*;

    localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

    ent_state_t state [`OOO_RS_DEPTH];
    op_t        e_op  [`OOO_RS_DEPTH];
    logic       rdy1  [`OOO_RS_DEPTH];
    logic       rdy2  [`OOO_RS_DEPTH];
    tag_t       tag1  [`OOO_RS_DEPTH];
    tag_t       tag2  [`OOO_RS_DEPTH];
    data_t      val1  [`OOO_RS_DEPTH];
    data_t      val2  [`OOO_RS_DEPTH];

    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             do_issue;

    // lowest free entry, scanned downward so the last hit wins
    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == ENT_FREE) begin
                has_free = 1'b1;
                free_idx = IDX_W'(i);
            end
        end
    end

    // lowest waiting entry with both operands in hand
    always_comb begin
        issue_valid = 1'b0;
        sel_idx     = '0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (state[i] == ENT_WAIT && rdy1[i] && rdy2[i]) begin
                issue_valid = 1'b1;
                sel_idx     = IDX_W'(i);
            end
        end
    end

    assign free_tag  = {UNIT, free_idx};
    assign issue_tag = {UNIT, sel_idx};
    assign issue_op  = e_op[sel_idx];
    assign issue_a   = val1[sel_idx];
    assign issue_b   = val2[sel_idx];
    assign do_issue  = issue_valid && exec_ready;

    // free -> wait -> issued -> free on own broadcast
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                state[i] <= ENT_FREE;
            end
        end else begin
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                if (alloc && free_idx == IDX_W'(i)) begin
                    state[i] <= ENT_WAIT;
                end else if (do_issue && sel_idx == IDX_W'(i)) begin
                    state[i] <= ENT_ISSUED;
                end else if (state[i] == ENT_ISSUED && cdb_valid
                             && cdb_tag == {UNIT, IDX_W'(i)}) begin
                    state[i] <= ENT_FREE;
                end
            end
        end
    end

    // entry fill on alloc, operand wakeup by snooping the bus
    always_ff @(posedge clk) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (alloc && free_idx == IDX_W'(i)) begin
                e_op[i] <= op;
                rdy1[i] <= src1_ready;
                tag1[i] <= src1_tag;
                val1[i] <= src1_val;
                rdy2[i] <= src2_ready;
                tag2[i] <= src2_tag;
                val2[i] <= src2_val;
            end else if (state[i] == ENT_WAIT && cdb_valid) begin
                if (!rdy1[i] && tag1[i] == cdb_tag) begin
                    rdy1[i] <= 1'b1;
                    val1[i] <= cdb_data;
                end
                if (!rdy2[i] && tag2[i] == cdb_tag) begin
                    rdy2[i] <= 1'b1;
                    val2[i] <= cdb_data;
                end
            end
        end
    end

endmodule

// ==== include/ooo_config.svh ====
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// architectural register count
`define OOO_NUM_REGS 8

// entries in each reservation station
`define OOO_RS_DEPTH 4

// operand and result width
`define OOO_XLEN 32

// multiplier pipeline depth
`define OOO_MUL_STAGES 3

`endif

// ==== tb.f ====
+incdir+include
hdl/ooo_pkg.sv
hdl/dispatch_rename.sv
hdl/reservation_station.sv
hdl/exec_units.sv
hdl/cdb_arbiter.sv
hdl/ooo_core.sv
tests/tb_ooo_core.sv

// ==== tests/tb_ooo_core.sv ====
`timescale 1ns/1ns
`include "ooo_config.svh"

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int N_LI        = `OOO_NUM_REGS;
    localparam int N_CHAIN     = 12;
    localparam int N_FULL      = 5;
    localparam int N_RAND      = 300;
    localparam int TOTAL_INSTR = N_LI + N_CHAIN + N_FULL + N_RAND;
    // 20 cycles of 40 ns per instruction
    localparam int WATCHDOG_NS = TOTAL_INSTR * 20 * 40;

    logic     clk;
    logic     rst_n;
    logic     disp_valid;
    op_t      disp_op;
    reg_idx_t disp_rd;
    reg_idx_t disp_rs1;
    reg_idx_t disp_rs2;
    data_t    disp_imm;
    logic     disp_ready;
    logic     cdb_valid;
    tag_t     cdb_tag;
    data_t    cdb_data;
    reg_idx_t arch_addr;
    data_t    arch_data;
    logic     idle;

    // architectural model, in program order
    data_t  model [`OOO_NUM_REGS];
    int     accepted;
    int     bcast_count;
    logic   saw_stall;
    integer seed;

    // results still owed by the core, with the unit that makes each
    data_t  pend_data [$];
    logic   pend_mul  [$];

    ooo_core u_dut (
        .clk, .rst_n, .disp_valid, .disp_op, .disp_rd, .disp_rs1, .disp_rs2, .disp_imm,
        .disp_ready, .cdb_valid, .cdb_tag, .cdb_data, .arch_addr, .arch_data, .idle
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    // a broadcast must retire one owed result of the same unit
    task automatic retire_broadcast();
        int i;
        i = 0;
        while (i < pend_data.size() && !(pend_mul[i] == cdb_tag[$bits(tag_t)-1]
                                        && pend_data[i] == cdb_data)) begin
            i++;
        end
        if (i >= pend_data.size()) begin
            abort_run($sformatf("broadcast at t=%0t with tag %h data %h matches no %s",
                                $time, cdb_tag, cdb_data, "outstanding instruction"));
        end
        pend_data.delete(i);
        pend_mul.delete(i);
    endtask

    // every broadcast seen mid-cycle
    always @(negedge clk) begin
        if (rst_n && cdb_valid) begin
            bcast_count++;
            retire_broadcast();
        end
    end

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got=%b exp=%b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[FAIL] t=%0t %s got=%0d exp=%0d", $time, name, got, exp));
        end
    endtask

    // architectural result of one instruction
    function automatic data_t expected_result(input op_t op, input data_t a, input data_t b,
                                              input data_t imm);
        case (op)
            OP_LI:   return imm;
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_MUL:  return a * b;
            default: return '0;
        endcase
    endfunction

    // called and left 2 ns after a rising edge
    task automatic send_instr(input op_t op, input int rd, input int rs1, input int rs2,
                              input data_t imm);
        data_t result;
        disp_valid = 1'b1;
        disp_op    = op;
        disp_rd    = reg_idx_t'(rd);
        disp_rs1   = reg_idx_t'(rs1);
        disp_rs2   = reg_idx_t'(rs2);
        disp_imm   = imm;
        @(negedge clk);
        // inputs hold while the station is full
        while (!disp_ready) begin
            saw_stall = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        result    = expected_result(op, model[rs1], model[rs2], imm);
        model[rd] = result;
        pend_data.push_back(result);
        pend_mul.push_back(op == OP_MUL);
        accepted++;
    endtask

    task automatic wait_idle();
        disp_valid = 1'b0;
        @(negedge clk);
        while (!idle) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2;
    endtask

    // walk the debug read port over every register
    task automatic compare_regs();
        for (int i = 0; i < `OOO_NUM_REGS; i++) begin
            arch_addr = reg_idx_t'(i);
            @(negedge clk);
            check_data($sformatf("r%0d", i), arch_data, model[i]);
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before all tests finished");
    end

    initial begin
        int n;
        int r_op;
        int r_rd;
        int r_rs1;
        int r_rs2;
        seed        = 32'hb751df14;
        rst_n       = 1'b0;
        disp_valid  = 1'b0;
        disp_op     = OP_LI;
        disp_rd     = '0;
        disp_rs1    = '0;
        disp_rs2    = '0;
        disp_imm    = '0;
        arch_addr   = '0;
        accepted    = 0;
        bcast_count = 0;
        saw_stall   = 1'b0;
        for (int i = 0; i < `OOO_NUM_REGS; i++) begin
            model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // reset state
        @(negedge clk);
        check_bit("disp_ready", disp_ready, 1'b1);
        check_bit("cdb_valid", cdb_valid, 1'b0);
        check_bit("idle", idle, 1'b1);
        @(posedge clk);
        #2;
        compare_regs();

        // immediates into every register
        for (n = 0; n < N_LI; n++) begin
            send_instr(OP_LI, n, 0, 0, data_t'($random(seed)));
        end
        wait_idle();
        check_count("broadcasts", bcast_count, N_LI);
        compare_regs();

        // dependent chain, raw through tags and bus bypass
        send_instr(OP_LI,  1, 0, 0, 32'h0000_0007);
        send_instr(OP_LI,  2, 0, 0, 32'h0000_0013);
        send_instr(OP_ADD, 3, 1, 2, '0);
        send_instr(OP_MUL, 4, 3, 2, '0);
        send_instr(OP_SUB, 5, 4, 1, '0);
        send_instr(OP_XOR, 6, 5, 3, '0);
        send_instr(OP_MUL, 7, 6, 4, '0);
        send_instr(OP_AND, 0, 7, 6, '0);
        send_instr(OP_OR,  1, 0, 5, '0);
        send_instr(OP_MUL, 2, 1, 1, '0);
        send_instr(OP_ADD, 3, 2, 7, '0);
        send_instr(OP_SUB, 4, 3, 2, '0);
        wait_idle();
        check_count("broadcasts", bcast_count, accepted);
        compare_regs();

        // five muls against a 4 entry station
        saw_stall = 1'b0;
        for (n = 0; n < N_FULL; n++) begin
            send_instr(OP_MUL, n + 1, n, n + 2, '0);
        end
        check_bit("disp_ready low before fifth mul", saw_stall, 1'b1);
        wait_idle();
        check_count("broadcasts", bcast_count, accepted);
        compare_regs();

        // random stream over r0..r3 only, heavy waw/war and tag reuse
        for (n = 0; n < N_RAND; n++) begin
            r_op  = $unsigned($random(seed)) % 7;
            r_rd  = $unsigned($random(seed)) % 4;
            r_rs1 = $unsigned($random(seed)) % 4;
            r_rs2 = $unsigned($random(seed)) % 4;
            send_instr(op_t'(r_op[2:0]), r_rd, r_rs1, r_rs2, data_t'($random(seed)));
            // occasional bubble in the stream
            if (($random(seed) & 15) == 0) begin
                disp_valid = 1'b0;
                @(posedge clk);
                #2;
            end
        end
        wait_idle();
        check_count("broadcasts", bcast_count, accepted);
        compare_regs();

        $display("test passed");
        $finish;
    end

endmodule
